/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

   // Request from one bus master, held stable while cyc is high until ack
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } wb_req_t;

   // Response back to a master. rdt is only meaningful while ack is high
   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } wb_rsp_t;

   // Destination of the access currently on the shared bus
   typedef enum logic [1:0] {
      TGT_MEM,
      TGT_GPIO,
      TGT_TIMER,
      TGT_NONE
   } target_e;

   // Regions are selected by address bits 31:30
   localparam logic [1:0] ADDR_MEM   = 2'd0;
   localparam logic [1:0] ADDR_GPIO  = 2'd1;
   localparam logic [1:0] ADDR_TIMER = 2'd2;

   // Word offset 0 of the timer region is mtime, offset 1 is mtimecmp
   localparam logic TIMER_CMP_OFS = 1'b1;

endpackage

`default_nettype wire

/* src/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter (
   input  wire               wb_clk,
   input  wire               i_rst,
   input  wire soc_pkg::wb_req_t i_ibus,
   input  wire soc_pkg::wb_req_t i_dbus,
   output soc_pkg::wb_rsp_t  o_ibus_rsp,
   output soc_pkg::wb_rsp_t  o_dbus_rsp,
   output soc_pkg::wb_req_t  o_req,
   input  wire soc_pkg::wb_rsp_t i_rsp
);
   import soc_pkg::*;

   typedef enum logic {
      OWN_IBUS,
      OWN_DBUS
   } owner_e;

   owner_e  owner_q;
   owner_e  owner_sel;
   logic    busy_q;
   wb_req_t ibus_req;

   // The instruction port only fetches
   always_comb begin
      ibus_req     = i_ibus;
      ibus_req.dat = '0;
      ibus_req.sel = '0;
      ibus_req.we  = 1'b0;
   end

   // An idle bus is handed over in the same cycle so an access costs one wait cycle
   always_comb begin
      if (busy_q) begin
         owner_sel = owner_q;
      end else if (i_ibus.cyc) begin
         owner_sel = OWN_IBUS;
      end else begin
         owner_sel = OWN_DBUS;
      end
   end

   always_comb begin
      o_req      = (owner_sel == OWN_IBUS) ? ibus_req : i_dbus;
      o_ibus_rsp = '0;
      o_dbus_rsp = '0;
      if (owner_sel == OWN_IBUS) begin
         o_ibus_rsp = i_rsp;
      end else begin
         o_dbus_rsp = i_rsp;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (i_rst) begin
         busy_q  <= 1'b0;
         owner_q <= OWN_IBUS;
      end else if (!busy_q) begin
         if (o_req.cyc) begin
            busy_q  <= 1'b1;
            owner_q <= owner_sel;  // Locked until the target answers
         end
      end else if (i_rsp.ack) begin
         busy_q <= 1'b0;
      end
   end

   // A master waiting behind an open access must never take over the bus
   a_owner_held: assert property (@(posedge wb_clk) disable iff (i_rst)
      (busy_q && !i_rsp.ack) |=> (owner_q == $past(owner_q)));

endmodule

`default_nettype wire

/* src/bus_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_decoder (
   input  wire               wb_clk,
   input  wire               i_rst,
   input  wire soc_pkg::wb_req_t i_req,
   output soc_pkg::wb_rsp_t  o_rsp,
   output logic              o_mem_cyc,
   output logic              o_periph_cyc,
   output soc_pkg::target_e  o_target,
   input  wire [31:0]        i_mem_rdt,
   input  wire [31:0]        i_periph_rdt
);
   import soc_pkg::*;

   target_e     tgt_dec;
   target_e     target_q;
   logic        ack_q;
   logic        strobe;
   logic [31:0] rdt_mux;

   always_comb begin
      case (i_req.adr[31:30])
         ADDR_MEM:   tgt_dec = TGT_MEM;
         ADDR_GPIO:  tgt_dec = TGT_GPIO;
         ADDR_TIMER: tgt_dec = TGT_TIMER;
         default:    tgt_dec = TGT_NONE;
      endcase
   end

   // Targets see a single strobe in the first cycle of each access
   assign strobe       = i_req.cyc && !ack_q;
   assign o_mem_cyc    = strobe && (tgt_dec == TGT_MEM);
   assign o_periph_cyc = strobe && ((tgt_dec == TGT_GPIO) || (tgt_dec == TGT_TIMER));
   assign o_target     = tgt_dec;

   // Unmapped accesses still complete so a master cannot hang
   always_ff @(posedge wb_clk) begin
      if (i_rst) begin
         ack_q    <= 1'b0;
         target_q <= TGT_NONE;
      end else begin
         ack_q <= strobe;
         if (strobe) begin
            target_q <= tgt_dec;
         end
      end
   end

   // Both targets register their read word at the strobe edge
   always_comb begin
      rdt_mux = '0;
      if (ack_q) begin
         case (target_q)
            TGT_MEM:   rdt_mux = i_mem_rdt;
            TGT_GPIO:  rdt_mux = i_periph_rdt;
            TGT_TIMER: rdt_mux = i_periph_rdt;
            default:   rdt_mux = '0;
         endcase
      end
   end

   assign o_rsp = '{rdt: rdt_mux, ack: ack_q};

   // The master sees ack and moves on, so a second ack would complete a phantom access
   a_ack_single: assert property (@(posedge wb_clk) disable iff (i_rst)
      ack_q |=> !ack_q);

endmodule

`default_nettype wire

/* src/wb_sram.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_sram #(
   parameter int MEM_WORDS = 2048
) (
   input  wire                         wb_clk,
   input  wire                         i_cyc,
   input  wire                         i_we,
   input  wire [3:0]                   i_sel,
   input  wire [$clog2(MEM_WORDS)-1:0] i_adr,
   input  wire [31:0]                  i_dat,
   output logic [31:0]                 o_rdt
);

   logic [31:0] mem [MEM_WORDS];

   // Read-first port. A write returns the word as it was before the edge
   always_ff @(posedge wb_clk) begin
      if (i_cyc) begin
         for (int b = 0; b < 4; b++) begin
            if (i_we && i_sel[b]) begin
               mem[i_adr][8*b +: 8] <= i_dat[8*b +: 8];
            end
         end
         o_rdt <= mem[i_adr];
      end
   end

endmodule

`default_nettype wire

/* src/sys_periph.sv */
`default_nettype none
`timescale 1ns/1ps

module sys_periph #(
   parameter int GPIO_WIDTH = 8
) (
   input  wire                    wb_clk,
   input  wire                    i_rst,
   input  wire                    i_cyc,
   input  wire soc_pkg::target_e  i_target,
   input  wire                    i_we,
   input  wire                    i_word,
   input  wire [31:0]             i_dat,
   output logic [31:0]            o_rdt,
   output logic [GPIO_WIDTH-1:0]  o_gpio,
   output logic                   o_timer_irq
);
   import soc_pkg::*;

   logic [GPIO_WIDTH-1:0] gpio_q;
   logic [31:0]           mtime_q;
   logic [31:0]           mtimecmp_q;
   logic [31:0]           gpio_ext;
   logic                  irq_q;
   logic                  gpio_wr;
   logic                  cmp_wr;

   assign gpio_wr  = i_cyc && i_we && (i_target == TGT_GPIO);
   assign cmp_wr   = i_cyc && i_we && (i_target == TGT_TIMER) && (i_word == TIMER_CMP_OFS);
   assign gpio_ext = 32'(gpio_q);

   always_ff @(posedge wb_clk) begin
      if (i_rst) begin
         gpio_q     <= '0;
         mtime_q    <= '0;
         mtimecmp_q <= '1;  // No interrupt until software programs a deadline
         irq_q      <= 1'b0;
      end else begin
         mtime_q <= mtime_q + 32'd1;
         irq_q   <= (mtime_q >= mtimecmp_q);
         if (gpio_wr) begin
            gpio_q <= i_dat[GPIO_WIDTH-1:0];
         end
         if (cmp_wr) begin
            mtimecmp_q <= i_dat;
         end
      end
   end

   // mtime is free running and read only from the bus
   always_ff @(posedge wb_clk) begin
      if (i_cyc) begin
         if (i_target == TGT_GPIO) begin
            o_rdt <= gpio_ext;
         end else if (i_word == TIMER_CMP_OFS) begin
            o_rdt <= mtimecmp_q;
         end else begin
            o_rdt <= mtime_q;
         end
      end
   end

   assign o_gpio      = gpio_q;
   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

/* src/wb_soc.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_soc #(
   parameter int MEM_WORDS  = 2048,
   parameter int GPIO_WIDTH = 8
) (
   input  wire                      wb_clk,
   input  wire                      i_rst,
   input  wire soc_pkg::wb_req_t    i_ibus,
   input  wire soc_pkg::wb_req_t    i_dbus,
   output wire soc_pkg::wb_rsp_t    o_ibus_rsp,
   output wire soc_pkg::wb_rsp_t    o_dbus_rsp,
   output wire [GPIO_WIDTH-1:0]     o_gpio,
   output wire                      o_timer_irq
);
   import soc_pkg::*;

   localparam int ADR_BITS = $clog2(MEM_WORDS);

   wb_req_t     bus_req;
   wb_rsp_t     bus_rsp;
   target_e     target;
   logic        mem_cyc;
   logic        periph_cyc;
   logic [31:0] mem_rdt;
   logic [31:0] periph_rdt;

   bus_arbiter arbiter_i (
      .wb_clk     (wb_clk),
      .i_rst      (i_rst),
      .i_ibus     (i_ibus),
      .i_dbus     (i_dbus),
      .o_ibus_rsp (o_ibus_rsp),
      .o_dbus_rsp (o_dbus_rsp),
      .o_req      (bus_req),
      .i_rsp      (bus_rsp)
   );

   bus_decoder decoder_i (
      .wb_clk       (wb_clk),
      .i_rst        (i_rst),
      .i_req        (bus_req),
      .o_rsp        (bus_rsp),
      .o_mem_cyc    (mem_cyc),
      .o_periph_cyc (periph_cyc),
      .o_target     (target),
      .i_mem_rdt    (mem_rdt),
      .i_periph_rdt (periph_rdt)
   );

   // Byte address in, word index out
   wb_sram #(.MEM_WORDS(MEM_WORDS)) sram_i (
      .wb_clk (wb_clk),
      .i_cyc  (mem_cyc),
      .i_we   (bus_req.we),
      .i_sel  (bus_req.sel),
      .i_adr  (bus_req.adr[ADR_BITS+1:2]),
      .i_dat  (bus_req.dat),
      .o_rdt  (mem_rdt)
   );

   sys_periph #(.GPIO_WIDTH(GPIO_WIDTH)) periph_i (
      .wb_clk      (wb_clk),
      .i_rst       (i_rst),
      .i_cyc       (periph_cyc),
      .i_target    (target),
      .i_we        (bus_req.we),
      .i_word      (bus_req.adr[2]),
      .i_dat       (bus_req.dat),
      .o_rdt       (periph_rdt),
      .o_gpio      (o_gpio),
      .o_timer_irq (o_timer_irq)
   );

endmodule

`default_nettype wire

/* dv/tb_wb_soc.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_wb_soc;
   import soc_pkg::*;

   localparam int MEM_WORDS  = 2048;
   localparam int GPIO_WIDTH = 8;

   typedef enum logic [1:0] {
      EXP_NONE,
      EXP_VALUE,
      EXP_MODEL,
      EXP_MTIME
   } exp_e;

   // One line of the cases file
   typedef struct packed {
      logic [7:0]            mode;
      logic                  we;
      logic [31:0]           adr;
      logic [31:0]           dat;
      logic [3:0]            sel;
      exp_e                  rdt_kind;
      logic [31:0]           rdt;
      logic [GPIO_WIDTH-1:0] gpio;
      logic                  irq_chk;
      logic                  irq;
   } case_t;

   logic                  wb_clk;
   logic                  i_rst;
   wb_req_t               ibus;
   wb_req_t               dbus;
   wb_rsp_t               ibus_rsp;
   wb_rsp_t               dbus_rsp;
   logic [GPIO_WIDTH-1:0] gpio;
   logic                  timer_irq;

   case_t       cases[$];
   logic [31:0] sram_model[int];  // Only words written through the dbus
   logic [31:0] last_mtime = '0;
   logic [15:0] lfsr = 16'd89;
   logic        loaded = 1'b0;
   int          error_count = 0;
   int          ibus_reqs = 0;
   int          dbus_reqs = 0;
   int          ibus_acks = 0;
   int          dbus_acks = 0;

   wb_soc #(.MEM_WORDS(MEM_WORDS), .GPIO_WIDTH(GPIO_WIDTH)) wb_soc_i (
      .wb_clk      (wb_clk),
      .i_rst       (i_rst),
      .i_ibus      (ibus),
      .i_dbus      (dbus),
      .o_ibus_rsp  (ibus_rsp),
      .o_dbus_rsp  (dbus_rsp),
      .o_gpio      (gpio),
      .o_timer_irq (timer_irq)
   );

   initial begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
      error_count++;
   endtask

   task automatic report_failure(input string msg);
      $display("error at %0d ns: %s", $time, msg);
      error_count++;
   endtask

   function automatic logic [31:0] hex_value(input logic [127:0] tok);
      logic [31:0] v;
      logic [7:0]  ch;
      v = '0;
      for (int k = 15; k >= 0; k--) begin
         ch = tok[8*k +: 8];
         if (ch >= "0" && ch <= "9")
            v = {v[27:0], 4'(ch - "0")};
         else if (ch >= "a" && ch <= "f")
            v = {v[27:0], 4'(ch - "a" + 8'd10)};
      end
      return v;
   endfunction

   // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic int gap_cycles();
      int g;
      g = 0;
      for (int k = 0; k < 2; k++) begin
         lfsr = lfsr_next(lfsr);
         g = (g << 1) | int'(lfsr[0]);
      end
      return g;
   endfunction

   function automatic int word_index(input logic [31:0] adr);
      return int'(adr[31:2] % MEM_WORDS);
   endfunction

   task automatic load_cases();
      int            fd;
      int            cnt;
      logic [127:0]  tok;
      logic [127:0]  rdt_tok;
      logic [127:0]  irq_tok;
      logic [2047:0] rest;
      logic [31:0]   v_we;
      logic [31:0]   v_adr;
      logic [31:0]   v_dat;
      logic [31:0]   v_sel;
      logic [31:0]   v_gpio;
      case_t         c;
      fd = $fopen("dv/soc_cases.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open dv/soc_cases.txt");
         return;
      end
      while (!$feof(fd)) begin
         cnt = $fscanf(fd, "%s", tok);
         if (cnt != 1)
            break;
         if (tok == "#") begin
            cnt = $fgets(rest, fd);
         end else begin
            cnt = $fscanf(fd, "%h %h %h %h %s %h %s", v_we, v_adr, v_dat, v_sel, rdt_tok,
                          v_gpio, irq_tok);
            if (cnt != 7)
               report_failure("malformed line in the cases file");
            c = '0;
            c.mode = tok[7:0];
            c.we = v_we[0];
            c.adr = v_adr;
            c.dat = v_dat;
            c.sel = v_sel[3:0];
            c.gpio = v_gpio[GPIO_WIDTH-1:0];
            c.rdt_kind = (rdt_tok == "-") ? EXP_NONE : (rdt_tok == "m") ? EXP_MODEL :
                         (rdt_tok == "t") ? EXP_MTIME : EXP_VALUE;
            c.rdt = hex_value(rdt_tok);
            c.irq_chk = (irq_tok != "-");
            c.irq = (irq_tok == "1");
            cases.push_back(c);
         end
      end
      $fclose(fd);
   endtask

   // Holds the request until ack and releases it in the following cycle
   task automatic run_access(input logic use_ibus, input case_t c, output logic [31:0] rdt,
                             output int lat);
      wb_req_t req;
      logic    seen;
      int      n;
      req = '0;
      req.adr = c.adr;
      req.dat = c.dat;
      req.sel = c.sel;
      req.we = c.we;
      req.cyc = 1'b1;
      seen = 1'b0;
      n = 0;
      rdt = '0;
      if (use_ibus) begin
         ibus = req;
         ibus_reqs++;
      end else begin
         dbus = req;
         dbus_reqs++;
      end
      while (!seen && n < 8) begin
         @(posedge wb_clk);
         #1;
         n++;
         seen = use_ibus ? ibus_rsp.ack : dbus_rsp.ack;
         rdt = use_ibus ? ibus_rsp.rdt : dbus_rsp.rdt;
      end
      lat = seen ? n : 0;
      if (!seen)
         report_failure($sformatf("no ack within 8 cycles on the %s", use_ibus ? "ibus" : "dbus"));
      @(posedge wb_clk);
      #2;
      if (use_ibus)
         ibus = '0;
      else
         dbus = '0;
   endtask

   task automatic check_read(input string name, input case_t c, input logic [31:0] rdt);
      logic [31:0] exp;
      case (c.rdt_kind)
         EXP_VALUE: begin
            if (rdt !== c.rdt)
               report_mismatch(name, c.rdt, rdt);
         end
         EXP_MODEL: begin
            exp = sram_model.exists(word_index(c.adr)) ? sram_model[word_index(c.adr)] : '0;
            if (rdt !== exp)
               report_mismatch(name, exp, rdt);
         end
         EXP_MTIME: begin
            if (rdt <= last_mtime)
               report_failure($sformatf("mtime did not increase, read %h after %h", rdt,
                                        last_mtime));
            last_mtime = rdt;
         end
         default: ;
      endcase
   endtask

   // Byte lanes merge into the expected SRAM word
   task automatic apply_write(input case_t c);
      logic [31:0] word;
      int          idx;
      idx = word_index(c.adr);
      word = sram_model.exists(idx) ? sram_model[idx] : '0;
      for (int b = 0; b < 4; b++) begin
         if (c.sel[b])
            word[8*b +: 8] = c.dat[8*b +: 8];
      end
      if (c.we && c.adr[31:30] == ADDR_MEM)
         sram_model[idx] = word;
   endtask

   task automatic check_outputs(input case_t c);
      int n;
      if (gpio !== c.gpio)
         report_mismatch("o_gpio", 32'(c.gpio), 32'(gpio));
      n = 0;
      while (c.irq_chk && timer_irq !== c.irq && n < 2) begin
         @(posedge wb_clk);
         #2;
         n++;
      end
      if (c.irq_chk && timer_irq !== c.irq)
         report_mismatch("o_timer_irq", 32'(c.irq), 32'(timer_irq));
   endtask

   task automatic run_single(input case_t c);
      logic [31:0] rdt;
      int          lat;
      run_access(c.mode == "i", c, rdt, lat);
      if (lat > 1)
         report_mismatch("ack latency", 32'd1, lat);
      check_read((c.mode == "i") ? "o_ibus_rsp.rdt" : "o_dbus_rsp.rdt", c, rdt);
      if (c.mode != "i")
         apply_write(c);
      check_outputs(c);
   endtask

   task automatic run_pair(input case_t ci, input case_t cd);
      logic [31:0] rdt_i;
      logic [31:0] rdt_d;
      int          lat_i;
      int          lat_d;
      fork
         run_access(1'b1, ci, rdt_i, lat_i);
         run_access(1'b0, cd, rdt_d, lat_d);
      join
      if (lat_i != 1)
         report_mismatch("ibus ack latency", 32'd1, lat_i);
      if (lat_d <= lat_i)
         report_failure("dbus was served before the ibus in a simultaneous access");
      check_read("o_ibus_rsp.rdt", ci, rdt_i);
      check_read("o_dbus_rsp.rdt", cd, rdt_d);
      apply_write(cd);
      check_outputs(cd);
   endtask

   always @(negedge wb_clk) begin
      if (!i_rst && ibus_rsp.ack)
         ibus_acks++;
      if (!i_rst && dbus_rsp.ack)
         dbus_acks++;
   end

   initial begin
      wait (loaded);
      repeat (cases.size() * 10 + 200) @(posedge wb_clk);
      $display("timeout after %0d cases worth of cycles", cases.size());
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int idx;
      int gap;
      i_rst = 1'b1;
      ibus = '0;
      dbus = '0;
      load_cases();
      loaded = 1'b1;
      repeat (16) @(posedge wb_clk);
      #2;
      i_rst = 1'b0;
      if (ibus_rsp.ack !== 1'b0)
         report_mismatch("o_ibus_rsp.ack", 32'd0, 32'(ibus_rsp.ack));
      if (dbus_rsp.ack !== 1'b0)
         report_mismatch("o_dbus_rsp.ack", 32'd0, 32'(dbus_rsp.ack));
      if (timer_irq !== 1'b0)
         report_mismatch("o_timer_irq", 32'd0, 32'(timer_irq));
      if (gpio !== '0)
         report_mismatch("o_gpio", 32'd0, 32'(gpio));
      idx = 0;
      while (idx < cases.size()) begin
         gap = gap_cycles();
         if (gap > 0) begin
            repeat (gap) @(posedge wb_clk);
            #2;
         end
         if (cases[idx].mode != "b") begin
            run_single(cases[idx]);
            idx++;
         end else if (idx + 1 < cases.size() && cases[idx+1].mode == "b") begin
            run_pair(cases[idx], cases[idx+1]);
            idx += 2;
         end else begin
            report_failure("a b line in the cases file has no partner");
            idx++;
         end
      end
      repeat (2) @(posedge wb_clk);
      if (ibus_acks != ibus_reqs)
         report_mismatch("ibus ack count", ibus_reqs, ibus_acks);
      if (dbus_acks != dbus_reqs)
         report_mismatch("dbus ack count", dbus_reqs, dbus_acks);
      $display("%0d errors in %0d cases, %0d ibus and %0d dbus accesses", error_count,
               cases.size(), ibus_reqs, dbus_reqs);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
src/soc_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/wb_sram.sv
src/sys_periph.sv
src/wb_soc.sv
dv/tb_wb_soc.sv

/* Bender.yml */
package:
  name: wb_soc

sources:
  - src/soc_pkg.sv
  - src/bus_arbiter.sv
  - src/bus_decoder.sv
  - src/wb_sram.sv
  - src/sys_periph.sv
  - src/wb_soc.sv
  - target: test
    files:
      - dv/tb_wb_soc.sv

/* dv/soc_cases.txt */
# mode we adr dat sel rdt gpio irq, all hex. Paired b lines run together, ibus line first
# rdt is a word, - for none, m for the byte-merged memory model, t for a rising mtime
d 1 00000000 deadbeef f - 00 0
d 1 00000004 0badf00d f - 00 -
d 1 00000010 12345678 f - 00 -
d 1 00000ffc 13579bdf f - 00 -
d 0 00000000 00000000 0 deadbeef 00 -
i 0 00000004 00000000 0 0badf00d 00 -
i 0 00000010 00000000 0 12345678 00 -
d 0 00000ffc 00000000 0 13579bdf 00 -
d 1 00000010 aabbccdd 2 - 00 -
d 1 00000010 aabbccdd 8 - 00 -
d 0 00000010 00000000 0 m 00 -
d 1 00000004 11223344 5 - 00 -
i 0 00000004 00000000 0 m 00 -
d 0 00000004 00000000 0 0b22f044 00 -
b 0 00000000 00000000 0 deadbeef 00 -
b 0 00000010 00000000 0 aa34cc78 00 -
b 0 00000010 00000000 0 m 00 -
b 1 00000008 cafebabe f - 00 -
d 0 00000008 00000000 0 cafebabe 00 -
d 1 40000000 1234a5c3 f - c3 -
d 0 40000000 00000000 0 000000c3 c3 -
d 0 80000000 00000000 0 t c3 -
d 0 80000000 00000000 0 t c3 -
d 1 80000000 00000000 f - c3 0
d 0 80000000 00000000 0 t c3 -
d 1 80000004 00000000 f - c3 1
d 0 80000004 00000000 0 00000000 c3 1
d 1 80000004 ffffffff f - c3 0
d 0 80000004 00000000 0 ffffffff c3 0
d 1 c0000010 55555555 f - c3 -
d 0 c0000010 00000000 0 00000000 c3 -
d 0 00000010 00000000 0 aa34cc78 c3 -
i 0 c0000000 00000000 0 00000000 c3 -
